//--- Makefile
TOP := rv_exec_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir \
		-f rv_exec_core.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result,
    output logic            overflow,
    output logic            compare
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic [4:0]      shamt;
    logic            add_ovf;
    logic            sub_ovf;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[4:0];

    // Signed overflow shows as a sign flip that the operand signs cannot explain.
    assign add_ovf = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign sub_ovf = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

    assign overflow = (op == alu_sub) ? sub_ovf : ((op == alu_add) && add_ovf);
    assign compare  = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, compare};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = sum;
        endcase
    end

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output decoded_t        decoded
);

    opcode_e         opcode;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // Only the six supported major opcodes are recognised.
    always_comb begin
        case (instr[6:0])
            op_reg,
            op_imm,
            op_lui,
            op_auipc,
            op_jal,
            op_jalr: opcode = opcode_e'(instr[6:0]);
            default: opcode = op_illegal;
        endcase
    end

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // J offset is reassembled from its scattered bits, already shifted left by one.
    assign imm_j = {
        {11{instr[31]}},
        instr[31],
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

    always_comb begin
        decoded.opcode = opcode;
        decoded.funct3 = instr[14:12];
        decoded.alt    = instr[30];
        decoded.rd     = instr[11:7];
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.pc     = pc;

        case (opcode)
            op_imm,
            op_jalr:  decoded.imm = imm_i;
            op_lui,
            op_auipc: decoded.imm = imm_u;
            op_jal:   decoded.imm = imm_j;
            default:  decoded.imm = '0;
        endcase
    end

endmodule

//--- hw/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [xlen-1:0] in_instr,
    output logic            out_valid,
    input  logic            out_ready,
    output result_t         out_result
);

    decoded_t        dec_in;
    decoded_t        dec_q;
    decoded_t        exec_dec;
    logic            dec_valid;
    result_t         exu_result;
    result_t         res_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic            res_free;
    logic            dec_advance;
    logic            accept;

    assign res_free    = !out_valid || out_ready;
    assign dec_advance = dec_valid && res_free;
    assign in_ready    = !dec_valid || dec_advance;
    assign accept      = in_valid && in_ready;

    rv_decoder u_decoder (
        .instr   (in_instr),
        .pc      (pc_q),
        .decoded (dec_in)
    );

    // Instructions execute in order, so the PC at execute time is the right one.
    always_comb begin
        exec_dec    = dec_q;
        exec_dec.pc = pc_q;
    end

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec_q.rs1),
        .raddr2 (dec_q.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (dec_advance && exu_result.we),
        .waddr  (exu_result.rd),
        .wdata  (exu_result.wdata)
    );

    rv_exu u_exu (
        .decoded   (exec_dec),
        .rs1_value (rdata1),
        .rs2_value (rdata2),
        .result    (exu_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            out_valid <= 1'b0;
            pc_q      <= reset_pc;
        end else begin
            if (accept) begin
                dec_valid <= 1'b1;
            end else if (dec_advance) begin
                dec_valid <= 1'b0;
            end
            if (dec_advance) begin
                out_valid <= 1'b1;
                pc_q      <= exu_result.next_pc;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q <= dec_in;
        end
        if (dec_advance) begin
            res_q <= exu_result;
        end
    end

    assign out_result = res_q;

    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
    ) else $error("out_result changed while stalled");

endmodule

//--- hw/rv_exu.sv
`timescale 1ns/1ps

module rv_exu import rv_pkg::*; (
    input  decoded_t        decoded,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    output result_t         result
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    alu_op_e         alu_op;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] ex_result;
    logic [xlen-1:0] pc_plus4;
    logic            is_jump;
    logic            legal;
    logic            writes_rd;

    // SUB exists only for register operands, while SRA/SRAI share funct3 101.
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic sub_en,
                                         input logic sra_en);
        case (funct3)
            3'b000:  arith_op = sub_en ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = sra_en ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    endfunction

    always_comb begin
        op_a      = rs1_value;
        op_b      = decoded.imm;
        alu_op    = alu_add;
        writes_rd = 1'b1;
        case (decoded.opcode)
            op_reg: begin
                op_b   = rs2_value;
                alu_op = arith_op(decoded.funct3, decoded.alt, decoded.alt);
            end
            op_imm:           alu_op = arith_op(decoded.funct3, 1'b0, decoded.alt);
            op_lui:           op_a = '0;
            op_auipc, op_jal: op_a = decoded.pc;
            op_jalr:          op_a = rs1_value;
            default: begin
                op_a      = '0;
                op_b      = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    rv_alu u_alu (
        .a        (op_a),
        .b        (op_b),
        .op       (alu_op),
        .result   (alu_result),
        .overflow (),
        .compare  ()
    );

    assign is_jump   = (decoded.opcode == op_jal) || (decoded.opcode == op_jalr);
    assign legal     = decoded.opcode != op_illegal;
    assign pc_plus4  = decoded.pc + 32'd4;
    // JALR targets are halfword aligned.
    assign ex_result = (decoded.opcode == op_jalr) ? {alu_result[xlen-1:1], 1'b0} : alu_result;

    always_comb begin
        result.pc        = decoded.pc;
        result.rd        = decoded.rd;
        result.ex_result = ex_result;
        result.wdata     = is_jump ? pc_plus4 : ex_result;
        result.we        = writes_rd && (decoded.rd != '0);
        result.next_pc   = is_jump ? ex_result : pc_plus4;
        result.illegal   = !legal;
    end

    always_comb begin
        a_illegal_no_write: assert (!(result.illegal && result.we))
            else $error("illegal instruction requested a register write");
    end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

    // Register width as fixed by RV32I.
    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Values match the 7-bit major opcode field of the instruction word.
    typedef enum logic [6:0] {
        op_illegal = 7'b0000000,
        op_reg     = 7'b0110011,
        op_imm     = 7'b0010011,
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111
    } opcode_e;

    // Encoded as {funct7[5], funct3} so the OP and OP-IMM mapping stays obvious.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b1000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_sra  = 4'b1101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111
    } alu_op_e;

    // One instruction after decode, waiting in the decode register.
    typedef struct packed {
        opcode_e         opcode;
        logic [2:0]      funct3;
        logic            alt;
        reg_addr_t       rd;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } decoded_t;

    // One packet on the output stream per executed instruction.
    typedef struct packed {
        logic [xlen-1:0] pc;
        reg_addr_t       rd;
        logic [xlen-1:0] wdata;
        logic            we;
        logic [xlen-1:0] ex_result;
        logic [xlen-1:0] next_pc;
        logic            illegal;
    } result_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  reg_addr_t       raddr1,
    input  reg_addr_t       raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,
    input  reg_addr_t       waddr,
    input  logic [xlen-1:0] wdata
);

    // x0 has no storage.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // The execution unit must already have dropped writes to x0.
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset) !(we && waddr == '0)
    ) else $error("register file write presented with waddr 0");

endmodule

//--- rv_exec_core.f
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_exu.sv
hw/rv_exec_core.sv
tests/rv_exec_core_tb.sv

//--- tests/rv_exec_core_tb.sv
`timescale 1ns/1ps

module rv_exec_core_tb import rv_pkg::*;;

    localparam logic [31:0] start_pc = 32'h0000_1000;
    // Number of instructions issued by the sequence below.
    localparam int num_instr = 105;

    logic clk = 1'b0;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic [31:0] in_instr;
    logic out_valid;
    logic out_ready;
    result_t out_result;

    integer seed = 32'h5b22;
    int errors = 0;
    logic stall_en = 1'b0;
    logic [31:0] sh_regs [0:31];
    logic [31:0] sh_pc;
    result_t exp_fifo [0:255];
    result_t exp_head;
    int push_cnt = 0;
    int pop_cnt;
    logic pending;
    logic take;

    rv_exec_core #(.reset_pc(start_pc)) DUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    always #20 clk = ~clk;

    assign exp_head = exp_fifo[pop_cnt[7:0]];
    assign pending  = push_cnt != pop_cnt;
    assign take     = out_valid && out_ready;

    always @(posedge clk) begin
        if (reset) begin
            pop_cnt <= 0;
        end else if (take) begin
            pop_cnt <= pop_cnt + 1;
        end
    end

    task automatic note_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        note_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    endtask

    a_pc: assert property (@(posedge clk) disable iff (reset)
        take && pending |-> out_result.pc == exp_head.pc)
        else report_mismatch("pc", $sampled(exp_head.pc), $sampled(out_result.pc));
    a_rd: assert property (@(posedge clk) disable iff (reset)
        take && pending |-> out_result.rd == exp_head.rd)
        else report_mismatch("rd", {27'b0, $sampled(exp_head.rd)},
                             {27'b0, $sampled(out_result.rd)});
    a_we: assert property (@(posedge clk) disable iff (reset)
        take && pending |-> out_result.we == exp_head.we)
        else report_mismatch("we", {31'b0, $sampled(exp_head.we)},
                             {31'b0, $sampled(out_result.we)});
    a_illegal: assert property (@(posedge clk) disable iff (reset)
        take && pending |-> out_result.illegal == exp_head.illegal)
        else report_mismatch("illegal", {31'b0, $sampled(exp_head.illegal)},
                             {31'b0, $sampled(out_result.illegal)});
    a_next_pc: assert property (@(posedge clk) disable iff (reset)
        take && pending |-> out_result.next_pc == exp_head.next_pc)
        else report_mismatch("next_pc", $sampled(exp_head.next_pc), $sampled(out_result.next_pc));
    // Data fields of an illegal instruction carry no meaning.
    a_wdata: assert property (@(posedge clk) disable iff (reset)
        take && pending && !exp_head.illegal |-> out_result.wdata == exp_head.wdata)
        else report_mismatch("wdata", $sampled(exp_head.wdata), $sampled(out_result.wdata));
    a_ex_result: assert property (@(posedge clk) disable iff (reset)
        take && pending && !exp_head.illegal |-> out_result.ex_result == exp_head.ex_result)
        else report_mismatch("ex_result", $sampled(exp_head.ex_result),
                             $sampled(out_result.ex_result));
    a_no_extra: assert property (@(posedge clk) disable iff (reset) take |-> pending)
        else note_error("packet taken while no result was expected");
    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else note_error("out_result changed while out_ready was low");

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic result_t expect_result(input reg_addr_t rd, input logic [31:0] wdata,
                                              input logic [31:0] ex, input logic [31:0] next_pc,
                                              input logic illegal);
        result_t r;
        r.pc        = sh_pc;
        r.rd        = rd;
        r.wdata     = wdata;
        r.we        = !illegal && rd != 5'd0;
        r.ex_result = ex;
        r.next_pc   = next_pc;
        r.illegal   = illegal;
        return r;
    endfunction

    // Called a couple of ns after a rising edge; returns at the same point after acceptance.
    task automatic issue(input logic [31:0] word, input result_t exp);
        in_valid = 1'b1;
        in_instr = word;
        do @(negedge clk); while (!in_ready);
        exp_fifo[push_cnt[7:0]] = exp;
        push_cnt++;
        if (exp.we) sh_regs[exp.rd] = exp.wdata;
        sh_pc = exp.next_pc;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic reg_insn(input logic alt, input reg_addr_t rs2, input reg_addr_t rs1,
                            input logic [2:0] f3, input reg_addr_t rd);
        logic [31:0] res;
        res = model_alu(f3, alt, sh_regs[rs1], sh_regs[rs2]);
        issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011},
              expect_result(rd, res, res, sh_pc + 32'd4, 1'b0));
    endtask

    task automatic imm_insn(input logic [2:0] f3, input logic [11:0] imm,
                            input reg_addr_t rs1, input reg_addr_t rd);
        logic [31:0] res;
        res = model_alu(f3, f3 == 3'd5 && imm[10], sh_regs[rs1], sext12(imm));
        issue({imm, rs1, f3, rd, 7'b0010011}, expect_result(rd, res, res, sh_pc + 32'd4, 1'b0));
    endtask

    task automatic upper_insn(input logic is_auipc, input logic [19:0] imm20, input reg_addr_t rd);
        logic [31:0] res;
        res = is_auipc ? sh_pc + {imm20, 12'b0} : {imm20, 12'b0};
        issue({imm20, rd, is_auipc ? 7'b0010111 : 7'b0110111},
              expect_result(rd, res, res, sh_pc + 32'd4, 1'b0));
    endtask

    task automatic jal_insn(input logic [20:0] off, input reg_addr_t rd);
        logic [31:0] target;
        target = sh_pc + {{11{off[20]}}, off[20:1], 1'b0};
        issue({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111},
              expect_result(rd, sh_pc + 32'd4, target, target, 1'b0));
    endtask

    task automatic jalr_insn(input logic [11:0] imm, input reg_addr_t rs1, input reg_addr_t rd);
        logic [31:0] target;
        target = (sh_regs[rs1] + sext12(imm)) & ~32'd1;
        issue({imm, rs1, 3'b000, rd, 7'b1100111},
              expect_result(rd, sh_pc + 32'd4, target, target, 1'b0));
    endtask

    task automatic illegal_insn(input logic [31:0] word);
        issue(word, expect_result(word[11:7], 32'd0, 32'd0, sh_pc + 32'd4, 1'b1));
    endtask

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'(1 + ($unsigned($random(seed)) % 15));
    endfunction

    // out_ready drops at random only once stalling is switched on.
    initial begin
        logic ready_next;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            ready_next = stall_en ? (($random(seed) & 7) > 2) : 1'b1;
            @(posedge clk);
            #2;
            out_ready = ready_next;
        end
    end

    initial begin
        #(num_instr * 20 * 40);
        $display("Watchdog expired before all instructions came out.");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [2:0] f3;
        int waited;
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = 32'd0;
        sh_pc = start_pc;
        for (int i = 0; i < 32; i++) sh_regs[i] = 32'd0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (in_ready && !out_valid) else note_error("handshake outputs wrong after reset");

        // Full 32-bit values through LUI plus ADDI, then the immediate extremes.
        for (int i = 1; i < 16; i++) begin
            rnd = $random(seed);
            upper_insn(1'b0, rnd[31:12], reg_addr_t'(i));
            imm_insn(3'd0, rnd[11:0], reg_addr_t'(i), reg_addr_t'(i));
        end
        imm_insn(3'd0, 12'hfff, 5'd0, 5'd16);
        imm_insn(3'd0, 12'h7ff, 5'd0, 5'd17);
        imm_insn(3'd0, 12'h800, 5'd0, 5'd18);

        for (int f = 0; f < 8; f++) reg_insn(1'b0, pick_reg(), pick_reg(), 3'(f), 5'd20);
        reg_insn(1'b1, pick_reg(), pick_reg(), 3'd0, 5'd21);
        // x18 is negative and x17 gives a shift of 31, so SRA and SRL differ.
        reg_insn(1'b1, 5'd17, 5'd18, 3'd5, 5'd22);
        rnd = $random(seed);
        imm_insn(3'd1, {7'b0, rnd[4:0]}, 5'd5, 5'd23);
        imm_insn(3'd5, {7'b0, rnd[9:5]}, 5'd6, 5'd24);
        imm_insn(3'd5, {7'b0100000, 1'b1, rnd[13:10]}, 5'd18, 5'd25);
        for (int f = 2; f < 8; f++) begin
            if (f != 5) imm_insn(3'(f), 12'($random(seed)), pick_reg(), 5'd19);
        end

        rnd = $random(seed);
        upper_insn(1'b0, rnd[31:12], 5'd21);
        upper_insn(1'b1, rnd[19:0], 5'd22);

        // AUIPC with a zero immediate exposes the PC after each jump.
        for (int i = 0; i < 2; i++) begin
            jal_insn(21'($random(seed)), 5'd23);
            upper_insn(1'b1, 20'd0, 5'd25);
            jalr_insn(12'($random(seed)), pick_reg(), 5'd24);
            upper_insn(1'b1, 20'd0, 5'd25);
        end

        imm_insn(3'd0, 12'h005, 5'd3, 5'd0);
        reg_insn(1'b0, 5'd0, 5'd0, 3'd0, 5'd26);
        illegal_insn(32'h1234_5003);
        illegal_insn(32'hffff_ffff);

        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            f3 = rnd[2:0];
            if (rnd[3]) begin
                reg_insn((f3 == 3'd0 || f3 == 3'd5) && rnd[4], 5'($random(seed)),
                         5'($random(seed)), f3, rnd[9:5]);
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                imm_insn(f3, {1'b0, f3 == 3'd5 && rnd[4], 5'b0, rnd[14:10]},
                         5'($random(seed)), rnd[9:5]);
            end else begin
                imm_insn(f3, rnd[31:20], 5'($random(seed)), rnd[9:5]);
            end
        end
        stall_en = 1'b0;

        waited = 0;
        while (pending && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (pending) begin
            note_error($sformatf("%0d expected results never came out", push_cnt - pop_cnt));
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d instructions issued, %0d errors", push_cnt, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
